/* source/mem_pkg.sv */
package mem_pkg;

   ////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////
   localparam int DATA_W          = 32;  // wishbone and memory word
   localparam int ADDR_W          = 29;  // byte address, 512 Mbytes
   localparam int MEM_WORDS       = 256; // modeled array, address wraps
   localparam int READ_BURST_LEN  = 8;   // words per read-ahead refill
   localparam int BLEN_W          = 6;   // burst length field holds words - 1
   localparam int WR_FIFO_DEPTH   = 16;
   localparam int RD_FIFO_DEPTH   = 16;
   localparam int CMD_FIFO_DEPTH  = 4;
   localparam int CNT_W           = 7;   // queue fill count
   localparam int CSR_MCB_RST_BIT = 29;  // self clearing port reset
   localparam int CSR_DEBUG_BIT   = 28;  // register reads return debug word

   // burst opcodes, same codes as the controller port used to take
   typedef enum logic [2:0] {
      WRITE_AP = 3'b010, // write with auto precharge
      READ_AP  = 3'b011  // read with auto precharge
   } mem_op_e;

   typedef enum logic [2:0] {
      ST_RST, ST_IDLE, ST_WR_FIFO, ST_WR_CMD, ST_RD_FIFO, ST_RD_CMD
   } seq_state_e;

   typedef struct packed {
      mem_op_e           op;
      logic [BLEN_W-1:0] blen; // words minus one
      logic [ADDR_W-1:0] addr; // byte address of first word
   } mem_cmd_t;

   // one pipelined wishbone request
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [DATA_W/8-1:0] sel;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   dat;
   } wb_req_t;

   typedef struct packed {
      logic             full;
      logic             empty;
      logic [CNT_W-1:0] count;
   } fifo_stat_t;

   typedef struct packed {
      logic [DATA_W-1:0]   data;
      logic [DATA_W/8-1:0] mask; // 1 masks the byte out
   } wr_beat_t;

endpackage

/* source/mem_port_fifo.sv */
`timescale 1ns/1ps

module mem_port_fifo import mem_pkg::*; #(
   parameter int WIDTH = DATA_W,
   parameter int DEPTH = 16            // power of two
) (
   input  logic             wb_clk,
   input  logic             rst_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] wdata_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] rdata_o,   // head word, valid while not empty
   output fifo_stat_t       stat_o
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [WIDTH-1:0] buf_q [DEPTH];   // circular storage
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i & ~stat_o.full;  // push on full is dropped
   assign do_pop  = pop_i & ~stat_o.empty;  // pop on empty is ignored

   assign rdata_o = buf_q[rd_ptr_q];        // first word falls through
   assign stat_o  = '{full: (cnt_q == CNT_W'(DEPTH)), empty: (cnt_q == '0), count: cnt_q};

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH
         if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;             // both or none
         endcase
      end
   end

   // payload only
   always_ff @(posedge wb_clk) begin
      if (do_push) buf_q[wr_ptr_q] <= wdata_i;
   end

endmodule

/* source/mem_burst_engine.sv */
`timescale 1ns/1ps

module mem_burst_engine import mem_pkg::*; (
   input  logic              wb_clk,
   // command queue
   input  mem_cmd_t          cmd_i,       // head of queue
   input  fifo_stat_t        cmd_stat_i,
   output logic              cmd_pop_o,
   // write queue
   input  wr_beat_t          wr_beat_i,
   output logic              wr_pop_o,
   // read queue
   input  fifo_stat_t        rd_stat_i,
   output logic              rd_push_o,
   output logic [DATA_W-1:0] rd_data_o
);

   localparam int WORD_AW = $clog2(MEM_WORDS);
   localparam int BYTES   = DATA_W / 8;
   localparam int BOFF    = $clog2(BYTES);     // byte offset bits in address

   ////////////////////////////////////////////////////////////
   // word array, contents survive every reset
   ////////////////////////////////////////////////////////////
   logic [DATA_W-1:0]  mem_q [MEM_WORDS] = '{default: '0};

   logic               busy_q = 1'b0;  // a burst is running
   mem_op_e            op_q;
   logic [BLEN_W-1:0]  blen_q;         // last beat index
   logic [BLEN_W-1:0]  beat_q;         // beats done so far
   logic [WORD_AW-1:0] word_q;         // current word, wraps
   logic               beat_go;

   // fetch the next command only between bursts
   assign cmd_pop_o = ~busy_q & ~cmd_stat_i.empty;

   // write beats are all queued before the command, one per cycle
   assign wr_pop_o  = busy_q & (op_q == WRITE_AP);
   // read data waits while the read queue is full
   assign rd_push_o = busy_q & (op_q == READ_AP) & ~rd_stat_i.full;
   assign rd_data_o = mem_q[word_q];

   assign beat_go = wr_pop_o | rd_push_o;

   ////////////////////////////////////////////////////////////
   // burst control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (cmd_pop_o) begin
         busy_q <= 1'b1;
         op_q   <= cmd_i.op;
         blen_q <= cmd_i.blen;
         beat_q <= '0;
         word_q <= cmd_i.addr[BOFF +: WORD_AW]; // drop byte offset, wrap high bits
      end else if (beat_go) begin
         word_q <= word_q + 1'b1;
         beat_q <= beat_q + 1'b1;
         if (beat_q == blen_q) begin
            busy_q <= 1'b0;                     // last beat, free next cycle
         end
      end
   end

   // byte masked write of each popped beat
   always_ff @(posedge wb_clk) begin
      if (wr_pop_o) begin
         for (int b = 0; b < BYTES; b++) begin
            if (!wr_beat_i.mask[b]) begin
               mem_q[word_q][8*b +: 8] <= wr_beat_i.data[8*b +: 8];
            end
         end
      end
   end

endmodule

/* source/mem_wb_sequencer.sv */
`timescale 1ns/1ps

module mem_wb_sequencer import mem_pkg::*; (
   input  logic              wb_clk,
   input  logic              port_rst_i,
   // memory wishbone, pipelined
   input  wb_req_t           wbm_req_i,
   output logic              wbm_ack_o,
   output logic              wbm_stall_o,
   output logic [DATA_W-1:0] wbm_dat_o,
   // command queue
   output mem_cmd_t          cmd_o,
   output logic              cmd_push_o,
   input  fifo_stat_t        cmd_stat_i,
   // write queue
   output wr_beat_t          wr_beat_o,
   output logic              wr_push_o,
   input  fifo_stat_t        wr_stat_i,
   // read queue
   input  logic [DATA_W-1:0] rd_data_i,
   output logic              rd_pop_o,
   input  fifo_stat_t        rd_stat_i,
   output logic [CNT_W-1:0]  rd_left_o
);

   seq_state_e        state_q;
   logic [CNT_W-1:0]  stb_cnt;    // beats accepted in this block
   logic [CNT_W-1:0]  ack_cnt;    // read acks given in this block
   logic [ADDR_W-1:0] adr_beg;    // first address of write batch
   logic [ADDR_W-1:0] adr_next;   // address of next word in read queue
   logic [CNT_W-1:0]  rd_left;    // words queued or in flight for us
   logic              rd_dummy;   // stale words being thrown away
   logic              beat_ok;
   logic              rd_beat;
   logic              addr_hit;
   logic              drain_pop;
   logic              ack_pop;

   ////////////////////////////////////////////////////////////
   // beat acceptance and queue strobes
   ////////////////////////////////////////////////////////////
   assign wbm_stall_o = wr_stat_i.full | cmd_stat_i.full;
   assign beat_ok     = wbm_req_i.cyc & wbm_req_i.stb & ~wbm_stall_o;
   assign rd_beat     = beat_ok & ~wbm_req_i.we;
   assign wr_push_o   = beat_ok & wbm_req_i.we;   // every write beat goes to the queue
   assign wr_beat_o   = '{data: wbm_req_i.dat, mask: ~wbm_req_i.sel};
   assign rd_left_o   = rd_left;

   // read-ahead holds the requested word, nothing left to discard
   assign addr_hit  = (wbm_req_i.addr == adr_next) & (rd_left != '0) & ~rd_dummy;
   assign drain_pop = rd_dummy & (rd_left != '0) & ~rd_stat_i.empty;

   always_comb begin
      ack_pop = 1'b0;
      case (state_q)
         ST_IDLE:    ack_pop = rd_beat & addr_hit & ~rd_stat_i.empty;
         ST_RD_FIFO: ack_pop = wbm_req_i.cyc & ((ack_cnt != stb_cnt) | rd_beat) &
                               ~rd_dummy & ~rd_stat_i.empty;
         default:    ack_pop = 1'b0;
      endcase
   end

   assign rd_pop_o = drain_pop | ack_pop;   // never both, split by rd_dummy

   ////////////////////////////////////////////////////////////
   // main state machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (port_rst_i) begin
         state_q    <= ST_RST;
         wbm_ack_o  <= 1'b0;
         cmd_push_o <= 1'b0;
         stb_cnt    <= '0;
         ack_cnt    <= '0;
         rd_left    <= '0;
         rd_dummy   <= 1'b0;
         adr_next   <= '0;
      end else begin
         wbm_ack_o  <= wr_push_o;                  // write ack one cycle after accept
         cmd_push_o <= 1'b0;
         if (beat_ok) stb_cnt <= stb_cnt + 1'b1;
         if (rd_pop_o) rd_left <= rd_left - 1'b1;
         if (ack_pop) begin
            wbm_ack_o <= 1'b1;
            wbm_dat_o <= rd_data_i;
            ack_cnt   <= ack_cnt + 1'b1;
            adr_next  <= adr_next + ADDR_W'(DATA_W / 8);
         end
         // drain done
         if (rd_dummy && rd_left == '0) begin
            if (state_q == ST_RD_FIFO || state_q == ST_RD_CMD) begin
               rd_left <= CNT_W'(READ_BURST_LEN);  // fresh burst follows the stale words
            end else begin
               rd_left <= '0;                      // after a write
            end
            rd_dummy <= 1'b0;
         end
         case (state_q)
            ST_RST: begin
               if (!wbm_req_i.cyc) begin          // let a running cycle end
                  rd_left  <= '0;
                  rd_dummy <= 1'b0;
                  state_q  <= ST_IDLE;
               end
            end
            ST_IDLE: begin
               stb_cnt <= CNT_W'(beat_ok);
               ack_cnt <= CNT_W'(ack_pop);
               if (beat_ok) begin
                  adr_beg <= wbm_req_i.addr;
                  if (wbm_req_i.we) begin
                     state_q <= ST_WR_FIFO;
                  end else if (addr_hit) begin
                     state_q <= ST_RD_FIFO;        // acked now or when the word lands
                  end else begin
                     // miss, throw away leftovers and fetch a new burst
                     rd_dummy <= 1'b1;
                     adr_next <= wbm_req_i.addr;
                     cmd_o    <= '{op: READ_AP, blen: BLEN_W'(READ_BURST_LEN - 1),
                                   addr: wbm_req_i.addr};
                     if (cmd_stat_i.full) begin
                        state_q <= ST_RD_CMD;
                     end else begin
                        cmd_push_o <= 1'b1;
                        state_q    <= ST_RD_FIFO;
                     end
                  end
               end
            end
            ST_WR_FIFO: begin
               if (wr_stat_i.full || !wbm_req_i.cyc) begin
                  cmd_o    <= '{op: WRITE_AP, blen: BLEN_W'(stb_cnt - 1'b1), addr: adr_beg};
                  rd_dummy <= 1'b1;                // every write empties the read-ahead
                  if (cmd_stat_i.full) begin
                     state_q <= ST_WR_CMD;
                  end else begin
                     cmd_push_o <= 1'b1;
                     state_q    <= ST_IDLE;
                  end
               end
            end
            ST_WR_CMD: begin
               if (!cmd_stat_i.full) begin
                  cmd_push_o <= 1'b1;
                  state_q    <= ST_IDLE;
               end
            end
            ST_RD_FIFO: begin
               if (wbm_req_i.cyc && ((ack_cnt != stb_cnt) || rd_beat)) begin
                  // buffer used up in mid cycle, refill from next address
                  if (!rd_dummy && rd_left == '0 && ack_cnt != '0) begin
                     cmd_o   <= '{op: READ_AP, blen: BLEN_W'(READ_BURST_LEN - 1),
                                  addr: adr_next};
                     rd_left <= CNT_W'(READ_BURST_LEN);
                     if (cmd_stat_i.full) begin
                        state_q <= ST_RD_CMD;
                     end else begin
                        cmd_push_o <= 1'b1;
                     end
                  end
               end else begin
                  state_q <= ST_IDLE;              // all acked or cycle gone
               end
            end
            ST_RD_CMD: begin
               if (!cmd_stat_i.full) begin
                  cmd_push_o <= 1'b1;              // command prepared earlier
                  state_q    <= ST_RD_FIFO;
               end
            end
            default: state_q <= ST_RST;
         endcase
      end
   end

endmodule

/* source/mem_csr.sv */
`timescale 1ns/1ps

module mem_csr import mem_pkg::*; (
   input  logic              wb_clk,
   input  logic              mem_rst_i,
   // register wishbone
   input  logic              wbr_cyc_i,
   input  logic              wbr_stb_i,
   input  logic              wbr_we_i,
   input  logic [1:0]        wbr_addr_i,
   input  logic [DATA_W-1:0] wbr_dat_i,
   output logic              wbr_ack_o,
   output logic [DATA_W-1:0] wbr_dat_o,
   // status from the port
   input  logic [DATA_W-1:0] debug_word_i,
   output logic              port_rst_o
);

   logic [DATA_W-1:0] ctrl_q;  // control register at address 0
   logic              wr_en;

   // one write per access, the ack closes it
   assign wr_en = wbr_cyc_i & wbr_stb_i & wbr_we_i & ~wbr_ack_o & (wbr_addr_i == 2'd0);

   always_ff @(posedge wb_clk) begin
      if (mem_rst_i) begin
         ctrl_q    <= '0;
         wbr_ack_o <= 1'b0;
      end else begin
         wbr_ack_o                <= wbr_cyc_i & wbr_stb_i & ~wbr_ack_o;
         ctrl_q[CSR_MCB_RST_BIT] <= 1'b0;  // self clearing, one cycle pulse
         if (wr_en) ctrl_q <= wbr_dat_i;
      end
   end

   assign port_rst_o = mem_rst_i | ctrl_q[CSR_MCB_RST_BIT];

   // debug select overrides every address
   assign wbr_dat_o = ctrl_q[CSR_DEBUG_BIT] ? debug_word_i :
                      (wbr_addr_i == 2'd0)  ? ctrl_q : '0;

endmodule

/* source/memory_top.sv */
`timescale 1ns/1ps

module memory_top import mem_pkg::*; (
   input  logic              wb_clk,
   input  logic              mem_rst,
   // memory wishbone
   input  wb_req_t           wbm_req_i,
   output logic              wbm_ack_o,
   output logic              wbm_stall_o,
   output logic [DATA_W-1:0] wbm_dat_o,
   // register wishbone
   input  logic              wbr_cyc_i,
   input  logic              wbr_stb_i,
   input  logic              wbr_we_i,
   input  logic [1:0]        wbr_addr_i,
   input  logic [DATA_W-1:0] wbr_dat_i,
   output logic              wbr_ack_o,
   output logic [DATA_W-1:0] wbr_dat_o
);

   logic              port_rst;   // external reset or register pulse
   mem_cmd_t          cmd_in, cmd_head;
   logic              cmd_push, cmd_pop;
   fifo_stat_t        cmd_stat;
   wr_beat_t          wr_in, wr_head;
   logic              wr_push, wr_pop;
   fifo_stat_t        wr_stat;
   logic [DATA_W-1:0] rd_in, rd_head;
   logic              rd_push, rd_pop;
   fifo_stat_t        rd_stat;
   logic [CNT_W-1:0]  rd_left;
   logic [DATA_W-1:0] debug_word;

   ////////////////////////////////////////////////////////////
   // debug word, rd_left on top then cmd, read and write queue flags
   ////////////////////////////////////////////////////////////
   assign debug_word = {rd_left[3:0], 2'b00, cmd_stat.full, cmd_stat.empty,
                        2'b00, rd_stat.full, rd_stat.empty, 1'b0, rd_stat.count,
                        2'b00, wr_stat.full, wr_stat.empty, 1'b0, wr_stat.count};

   mem_csr u_csr (.wb_clk, .mem_rst_i(mem_rst), .wbr_cyc_i, .wbr_stb_i, .wbr_we_i,
      .wbr_addr_i, .wbr_dat_i, .wbr_ack_o, .wbr_dat_o,
      .debug_word_i(debug_word), .port_rst_o(port_rst));

   mem_wb_sequencer u_seq (.wb_clk, .port_rst_i(port_rst), .wbm_req_i, .wbm_ack_o,
      .wbm_stall_o, .wbm_dat_o, .cmd_o(cmd_in), .cmd_push_o(cmd_push), .cmd_stat_i(cmd_stat),
      .wr_beat_o(wr_in), .wr_push_o(wr_push), .wr_stat_i(wr_stat), .rd_data_i(rd_head),
      .rd_pop_o(rd_pop), .rd_stat_i(rd_stat), .rd_left_o(rd_left));

   // three queues between the bridge and the burst engine
   mem_port_fifo #(.WIDTH($bits(mem_cmd_t)), .DEPTH(CMD_FIFO_DEPTH)) u_cmd_fifo (.wb_clk,
      .rst_i(port_rst), .push_i(cmd_push), .wdata_i(cmd_in), .pop_i(cmd_pop),
      .rdata_o(cmd_head), .stat_o(cmd_stat));
   mem_port_fifo #(.WIDTH($bits(wr_beat_t)), .DEPTH(WR_FIFO_DEPTH)) u_wr_fifo (.wb_clk,
      .rst_i(port_rst), .push_i(wr_push), .wdata_i(wr_in), .pop_i(wr_pop),
      .rdata_o(wr_head), .stat_o(wr_stat));
   mem_port_fifo #(.WIDTH(DATA_W), .DEPTH(RD_FIFO_DEPTH)) u_rd_fifo (.wb_clk,
      .rst_i(port_rst), .push_i(rd_push), .wdata_i(rd_in), .pop_i(rd_pop),
      .rdata_o(rd_head), .stat_o(rd_stat));

   mem_burst_engine u_engine (.wb_clk, .cmd_i(cmd_head), .cmd_stat_i(cmd_stat),
      .cmd_pop_o(cmd_pop), .wr_beat_i(wr_head), .wr_pop_o(wr_pop), .rd_stat_i(rd_stat),
      .rd_push_o(rd_push), .rd_data_o(rd_in));

endmodule

/* tb/tb_memory_tasks.svh */
////////////////////////////////////////////////////////////
// reference model and counters
////////////////////////////////////////////////////////////
int                n_checks   = 0;
int                n_errors   = 0;
int                row_errors = 0;    // errors of the running test
integer            seed       = 4;    // write data stream
logic [DATA_W-1:0] ref_mem [MEM_WORDS]; // expected array contents

// word slot of a byte address, the array wraps at its depth
function automatic int word_index(input logic [ADDR_W-1:0] addr);
   return int'((addr / (DATA_W / 8)) % MEM_WORDS);
endfunction

// lanes with sel set take the new bytes
function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
   input logic [DATA_W-1:0] new_w, input logic [DATA_W/8-1:0] sel);
   logic [DATA_W-1:0] res;
   res = old_w;
   for (int b = 0; b < DATA_W / 8; b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
   end
   return res;
endfunction

task automatic report_problem(input string msg);
   n_errors++;
   row_errors++;
   $display("error: %s at %0t", msg, $time);
endtask

task automatic check_word(input string name, input logic [DATA_W-1:0] got,
   input logic [DATA_W-1:0] exp);
   n_checks++;
   if (got !== exp) begin
      n_errors++;
      row_errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
   end
endtask

// only the bits under mask are compared
task automatic check_csr(input string name, input logic [DATA_W-1:0] got,
   input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] mask);
   n_checks++;
   if ((got & mask) !== (exp & mask)) begin
      n_errors++;
      row_errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h mask 0x%h", name, got, exp, mask);
   end
endtask

////////////////////////////////////////////////////////////
// bus tasks, inputs change 1 ns after the clock edge
////////////////////////////////////////////////////////////
task automatic bus_idle(input int cycles);
   repeat (cycles) begin
      @(posedge wb_clk);
      #1;
      wbm_req = '0;
      if (wbm_ack) report_problem("memory port acked with no beat outstanding");
   end
endtask

task automatic write_words(input logic [ADDR_W-1:0] addr, input int len,
   input logic [DATA_W/8-1:0] sel, output bit stall_seen);
   int                sent;
   int                acks;
   bit                beat_live;           // a beat was taken at this edge
   logic [DATA_W-1:0] data;
   logic [ADDR_W-1:0] a;
   sent       = 0;
   acks       = 0;
   beat_live  = 1'b0;
   stall_seen = 1'b0;
   data       = $random(seed);
   while (acks < len) begin
      @(posedge wb_clk);
      #1;
      // ack belongs to the beat taken at the edge just passed
      if (wbm_ack !== beat_live) begin
         if (beat_live) report_problem("write beat not acked on the following cycle");
         else report_problem("write ack without a beat accepted on the last edge");
      end
      if (wbm_ack) acks++;
      beat_live = 1'b0;
      if (sent < len) begin
         a       = addr + ADDR_W'(sent * (DATA_W / 8));
         wbm_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: sel, addr: a, dat: data};
         if (wbm_stall) begin
            stall_seen = 1'b1;             // beat held for the next cycle
         end else begin
            ref_mem[word_index(a)] = merge_bytes(ref_mem[word_index(a)], data, sel);
            sent++;
            beat_live = 1'b1;
            data = $random(seed);
         end
      end else begin
         wbm_req.stb = 1'b0;               // cyc stays up until the last ack
      end
   end
   wbm_req = '0;
endtask

task automatic read_words(input logic [ADDR_W-1:0] addr, input int len);
   int                sent;
   int                acks;
   logic [ADDR_W-1:0] a;
   sent = 0;
   acks = 0;
   while (acks < len) begin
      @(posedge wb_clk);
      #1;
      if (wbm_ack) begin
         if (acks >= sent) report_problem("read ack without an accepted beat");
         a = addr + ADDR_W'(acks * (DATA_W / 8));   // acks come in address order
         check_word($sformatf("wbm_dat_o @0x%h", a), wbm_dat, ref_mem[word_index(a)]);
         acks++;
      end
      if (sent < len) begin
         a       = addr + ADDR_W'(sent * (DATA_W / 8));
         wbm_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: '1, addr: a, dat: '0};
         if (!wbm_stall) sent++;
      end else begin
         wbm_req.stb = 1'b0;
      end
   end
   wbm_req = '0;
endtask

// single register access, data sampled with the ack
task automatic csr_access(input logic we, input logic [1:0] addr,
   input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
   @(posedge wb_clk);
   #1;
   wbr_cyc  = 1'b1;
   wbr_stb  = 1'b1;
   wbr_we   = we;
   wbr_addr = addr;
   wbr_wdat = wdata;
   do begin
      @(posedge wb_clk);
      #1;
   end while (!wbr_ack);
   rdata   = wbr_rdat;
   wbr_cyc = 1'b0;
   wbr_stb = 1'b0;
   wbr_we  = 1'b0;
endtask

/* tb/tb_memory_top.sv */
`timescale 1ns/1ps

module tb_memory_top import mem_pkg::*; ();

   localparam int CLK_NS        = 8;
   localparam int N_TESTS       = 6;
   localparam int DBG_LEFT_LSB  = 28;  // rd_left nibble in the debug word
   localparam int DBG_CMD_EMPTY = 24;  // cmd full sits one above

   typedef enum logic [1:0] {K_WRBACK, K_READ, K_WR_AHEAD, K_DEBUG} test_kind_e;

   typedef struct packed {
      test_kind_e          kind;
      logic [ADDR_W-1:0]   addr;   // first byte address
      logic [7:0]          len;    // words
      logic [DATA_W/8-1:0] sel;    // byte select of the writes
   } test_row_t;

   test_row_t table_q [N_TESTS] = '{
      '{K_WRBACK,   29'h000, 8'd4,  4'hf},  // short burst, read back
      '{K_WRBACK,   29'h004, 8'd1,  4'h5},  // lanes 0 and 2 only
      '{K_WRBACK,   29'h040, 8'd24, 4'hf},  // longer than the write queue
      '{K_READ,     29'h044, 8'd12, 4'hf},  // crosses one refill
      '{K_WR_AHEAD, 29'h100, 8'd1,  4'hf},  // write kills read-ahead
      '{K_DEBUG,    29'h180, 8'd4,  4'hf}   // debug word, then port reset
   };

   logic              wb_clk;
   logic              mem_rst;
   wb_req_t           wbm_req;
   logic              wbm_ack;
   logic              wbm_stall;
   logic [DATA_W-1:0] wbm_dat;
   logic              wbr_cyc, wbr_stb, wbr_we, wbr_ack;
   logic [1:0]        wbr_addr;
   logic [DATA_W-1:0] wbr_wdat, wbr_rdat;

   memory_top dut_i (.wb_clk, .mem_rst, .wbm_req_i(wbm_req), .wbm_ack_o(wbm_ack),
      .wbm_stall_o(wbm_stall), .wbm_dat_o(wbm_dat), .wbr_cyc_i(wbr_cyc), .wbr_stb_i(wbr_stb),
      .wbr_we_i(wbr_we), .wbr_addr_i(wbr_addr), .wbr_dat_i(wbr_wdat), .wbr_ack_o(wbr_ack),
      .wbr_dat_o(wbr_rdat));

   `include "tb_memory_tasks.svh"

   ////////////////////////////////////////////////////////////
   // one table row
   ////////////////////////////////////////////////////////////
   task automatic run_row(input test_row_t row);
      logic [DATA_W-1:0] rdata;
      bit                stall_seen;
      case (row.kind)
         K_WRBACK: begin
            write_words(row.addr, row.len, row.sel, stall_seen);
            if (row.len > WR_FIFO_DEPTH && !stall_seen)
               report_problem("burst longer than the write queue never saw stall");
            bus_idle(2);                                   // command goes out
            read_words(row.addr, row.len);
         end
         K_READ: read_words(row.addr, row.len);
         K_WR_AHEAD: begin
            read_words(row.addr, 1);                       // fills read-ahead
            bus_idle(2);
            write_words(row.addr + ADDR_W'(DATA_W / 8), 1, row.sel, stall_seen);
            bus_idle(2);
            read_words(row.addr + ADDR_W'(DATA_W / 8), row.len);
         end
         K_DEBUG: begin
            csr_access(1'b1, 2'd0, DATA_W'(1) << CSR_DEBUG_BIT, rdata);
            read_words(row.addr, 1);
            bus_idle(2 * READ_BURST_LEN);                  // burst runs to its end
            csr_access(1'b0, 2'd0, '0, rdata);
            check_csr("wbr_dat_o debug", rdata,
               (DATA_W'(READ_BURST_LEN - 1) << DBG_LEFT_LSB) | (DATA_W'(1) << DBG_CMD_EMPTY),
               (DATA_W'(4'hf) << DBG_LEFT_LSB) | (DATA_W'(3) << DBG_CMD_EMPTY));
            csr_access(1'b1, 2'd0, DATA_W'(1) << CSR_MCB_RST_BIT, rdata);
            csr_access(1'b0, 2'd0, '0, rdata);
            check_csr("wbr_dat_o ctrl", rdata, '0, '1);   // reset bit gone
            bus_idle(2);
            read_words('0, row.len);                       // array kept its words
         end
         default: report_problem("unknown test kind in table");
      endcase
      bus_idle(2);
   endtask

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_NS / 2) wb_clk = ~wb_clk;
   end

   initial begin : stimulus
      mem_rst  = 1'b1;
      wbm_req  = '0;
      wbr_cyc  = 1'b0;
      wbr_stb  = 1'b0;
      wbr_we   = 1'b0;
      wbr_addr = '0;
      wbr_wdat = '0;
      foreach (ref_mem[i]) ref_mem[i] = '0;     // array powers up cleared
      repeat (5) @(posedge wb_clk);
      #1;
      mem_rst = 1'b0;
      bus_idle(2);
      for (int t = 0; t < N_TESTS; t++) begin
         row_errors = 0;
         run_row(table_q[t]);
         $display("test %0d %s @0x%h: %0d error(s)", t + 1, table_q[t].kind.name(),
            table_q[t].addr, row_errors);
      end
      $display("%0d tests, %0d checks, %0d errors", N_TESTS, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // 400 ns per row plus eight cycles per word
   initial begin : watchdog
      int      words;
      realtime limit;
      words = 0;
      foreach (table_q[t]) words += table_q[t].len;
      limit = N_TESTS * 400.0 + words * 8.0 * CLK_NS;
      #(limit);
      $display("error: watchdog expired at %0t, the DUT stopped answering", $time);
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* memory_bridge.f */
+incdir+tb
source/mem_pkg.sv
source/mem_port_fifo.sv
source/mem_burst_engine.sv
source/mem_wb_sequencer.sv
source/mem_csr.sv
source/memory_top.sv
tb/tb_memory_top.sv

/* Bender.yml */
package:
  name: memory_bridge

sources:
  - files:
      - source/mem_pkg.sv
      - source/mem_port_fifo.sv
      - source/mem_burst_engine.sv
      - source/mem_wb_sequencer.sv
      - source/mem_csr.sv
      - source/memory_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_memory_top.sv
